// File: rtl/usb_tx_pkg.sv
// Line timing, protocol constants, state encodings and PID layout for the USB transmit path.
package usb_tx_pkg;

	// ----------------------------------------------------------
	// line timing
	// ----------------------------------------------------------
	localparam int BIT_CLKS = 4;                    // clocks per full-speed bit time.
	localparam int BIT_CNT_W = $clog2(BIT_CLKS);
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(BIT_CLKS - 1);

	localparam int STUFF_RUN = 6;                   // ones sent before a zero is forced.
	localparam int RUN_W = $clog2(STUFF_RUN + 1);
	localparam logic [RUN_W-1:0] RUN_LIMIT = RUN_W'(STUFF_RUN);

	localparam int EOP_SE0_BITS = 2;
	localparam int SE0_W = $clog2(EOP_SE0_BITS + 1);
	localparam logic [SE0_W-1:0] SE0_LAST = SE0_W'(EOP_SE0_BITS - 1);

	localparam int FIFO_DEPTH = 8;                  // the host also starts with this many credits.
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
	localparam logic [CNT_W-1:0] FIFO_FULL = CNT_W'(FIFO_DEPTH);

	// ----------------------------------------------------------
	// protocol
	// ----------------------------------------------------------
	localparam logic [7:0] SYNC_BYTE = 8'h80;       // sent LSB first as KJKJKJKK.
	localparam logic [15:0] CRC16_POLY = 16'h8005;
	localparam logic [15:0] CRC16_INIT = 16'hFFFF;

	// serializer states.
	localparam logic [2:0] SER_IDLE = 3'd0;
	localparam logic [2:0] SER_SYNC = 3'd1;
	localparam logic [2:0] SER_PID = 3'd2;
	localparam logic [2:0] SER_DATA = 3'd3;
	localparam logic [2:0] SER_CRC = 3'd4;
	localparam logic [2:0] SER_WAIT_EOP = 3'd5;

	// line encoder states.
	localparam logic [1:0] ENC_IDLE = 2'd0;
	localparam logic [1:0] ENC_DATA = 2'd1;
	localparam logic [1:0] ENC_SE0 = 2'd2;
	localparam logic [1:0] ENC_J = 2'd3;

	typedef union packed
	{
		logic [7:0] raw;                        // the byte exactly as it goes on the wire.
		struct packed
		{
			logic [3:0] check;              // complement of pid.
			logic [3:0] pid;
		} fields;
	} usb_pid_byte_t;

endpackage

// File: rtl/usb_tx_fifo.sv
// Byte FIFO with last flag between the host and the serializer, returning one credit per pop.
`timescale 1ns/100ps

module usb_tx_fifo
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       in_valid,
	input  logic [7:0] in_byte,
	input  logic       in_last,
	input  logic       fifo_pop,
	output logic [7:0] fifo_byte,
	output logic       fifo_last,
	output logic       fifo_empty,
	output logic       credit_return
);

	logic [8:0] mem [usb_tx_pkg::FIFO_DEPTH];
	logic [usb_tx_pkg::PTR_W-1:0] wr_ptr;
	logic [usb_tx_pkg::PTR_W-1:0] rd_ptr;
	logic [usb_tx_pkg::CNT_W-1:0] count;

	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= {in_last, in_byte};
	end

	// head entry is visible without a pop.
	assign {fifo_last, fifo_byte} = mem[rd_ptr];
	assign fifo_empty = (count == '0);

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= (wr_ptr == usb_tx_pkg::PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (fifo_pop)
				rd_ptr <= (rd_ptr == usb_tx_pkg::PTR_LAST) ? '0 : rd_ptr + 1'b1;

			case ({in_valid, fifo_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			credit_return <= fifo_pop;            // the freed slot goes back to the host.
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	a_credit_overflow: assert property (@(posedge clk) disable iff (!n_rst)
		in_valid |-> (count != usb_tx_pkg::FIFO_FULL))
		else $error("push into a full FIFO, host spent a credit it did not hold");

	a_pop_empty: assert property (@(posedge clk) disable iff (!n_rst)
		fifo_pop |-> !fifo_empty)
		else $error("pop from an empty FIFO");

endmodule

// File: rtl/usb_pkt_serializer.sv
// Packet sequencer that sends SYNC, PID and data bits LSB first and marks the CRC phase.
`timescale 1ns/100ps

module usb_pkt_serializer
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic [7:0] fifo_byte,
	input  logic       fifo_last,
	input  logic       fifo_empty,
	input  logic       bit_strobe,
	input  logic       tx_hold,
	input  logic       eop_done,
	output logic       fifo_pop,
	output logic       tx_bit,
	output logic       pkt_active,
	output logic       crc_phase,
	output logic       crc_clear,
	output logic       crc_enable,
	output logic       create_eop
);

	logic [2:0] state;
	logic [7:0] shreg;
	logic [3:0] bit_cnt;
	usb_tx_pkg::usb_pid_byte_t pid_reg;
	logic pid_last;
	logic cur_last;
	logic advance;
	logic byte_done;
	logic is_data;
	logic start;

	assign advance = bit_strobe && !tx_hold;        // a stuffed slot does not consume a bit.
	assign byte_done = advance && (bit_cnt == 4'd7);
	assign is_data = (pid_reg.fields.pid[1:0] == 2'b11);
	assign start = (state == usb_tx_pkg::SER_IDLE) && !fifo_empty;

	// PID comes out on the first SYNC bit, every later byte as the one before it ends.
	assign fifo_pop = (advance && state == usb_tx_pkg::SER_SYNC && bit_cnt == 4'd0)
		|| (byte_done && state == usb_tx_pkg::SER_PID && !pid_last)
		|| (byte_done && state == usb_tx_pkg::SER_DATA && !cur_last);

	assign tx_bit = shreg[0];
	assign pkt_active = (state != usb_tx_pkg::SER_IDLE) && (state != usb_tx_pkg::SER_WAIT_EOP);
	assign crc_phase = (state == usb_tx_pkg::SER_CRC);
	assign crc_enable = (state == usb_tx_pkg::SER_DATA);
	assign crc_clear = start;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			state <= usb_tx_pkg::SER_IDLE;
			bit_cnt <= '0;
			create_eop <= 1'b0;
		end
		else
		begin
			create_eop <= 1'b0;
			case (state)
				usb_tx_pkg::SER_IDLE:
				begin
					bit_cnt <= '0;
					if (start)
						state <= usb_tx_pkg::SER_SYNC;
				end
				usb_tx_pkg::SER_SYNC:
				begin
					if (byte_done)
						state <= usb_tx_pkg::SER_PID;
					if (advance)
						bit_cnt <= byte_done ? 4'd0 : bit_cnt + 1'b1;
				end
				usb_tx_pkg::SER_PID,
				usb_tx_pkg::SER_DATA:
				begin
					if (byte_done)
					begin
						bit_cnt <= '0;
						if (fifo_pop)
							state <= usb_tx_pkg::SER_DATA;
						else if (is_data)
							state <= usb_tx_pkg::SER_CRC;
						else
						begin
							state <= usb_tx_pkg::SER_WAIT_EOP;  // tokens and handshakes carry no CRC.
							create_eop <= 1'b1;
						end
					end
					else if (advance)
						bit_cnt <= bit_cnt + 1'b1;
				end
				usb_tx_pkg::SER_CRC:
				begin
					if (advance)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd15)
						begin
							state <= usb_tx_pkg::SER_WAIT_EOP;
							create_eop <= 1'b1;
						end
					end
				end
				usb_tx_pkg::SER_WAIT_EOP:
				begin
					if (eop_done)
						state <= usb_tx_pkg::SER_IDLE;
				end
				default: state <= usb_tx_pkg::SER_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			shreg <= usb_tx_pkg::SYNC_BYTE;
		else if (byte_done && state == usb_tx_pkg::SER_SYNC)
			shreg <= pid_reg.raw;
		else if (fifo_pop && state != usb_tx_pkg::SER_SYNC)
			shreg <= fifo_byte;
		else if (advance)
			shreg <= {1'b0, shreg[7:1]};

		if (fifo_pop && state == usb_tx_pkg::SER_SYNC)
		begin
			pid_reg.raw <= fifo_byte;
			pid_last <= fifo_last;
		end
		if (fifo_pop && state != usb_tx_pkg::SER_SYNC)
			cur_last <= fifo_last;
	end

	a_no_underrun: assert property (@(posedge clk) disable iff (!n_rst)
		(byte_done && ((state == usb_tx_pkg::SER_PID && !pid_last)
		|| (state == usb_tx_pkg::SER_DATA && !cur_last))) |-> !fifo_empty)
		else $error("FIFO underrun in the middle of a packet");

endmodule

// File: rtl/usb_crc16.sv
// Serial CRC16 generator that follows the serializer bits and shifts out the inverted remainder.
`timescale 1ns/100ps

module usb_crc16
(
	input  logic clk,
	input  logic n_rst,
	input  logic crc_clear,
	input  logic crc_enable,
	input  logic crc_phase,
	input  logic tx_bit,
	input  logic bit_strobe,
	input  logic tx_hold,
	output logic crc_bit
);

	logic [15:0] crc;
	logic advance;
	logic feedback;

	assign advance = bit_strobe && !tx_hold;
	assign feedback = crc[15] ^ tx_bit;

	// ----------------------------------------------------------
	// LFSR, fed in wire order
	// ----------------------------------------------------------
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			crc <= usb_tx_pkg::CRC16_INIT;
		end
		else if (crc_clear)
		begin
			crc <= usb_tx_pkg::CRC16_INIT;
		end
		else if (advance && crc_enable)
		begin
			crc <= {crc[14:0], 1'b0} ^ (feedback ? usb_tx_pkg::CRC16_POLY : 16'h0000);
		end
		else if (advance && crc_phase)
		begin
			crc <= {crc[14:0], 1'b0};            // remainder leaves from the top.
		end
	end

	// the encoder takes this only while the serializer is in its CRC phase.
	assign crc_bit = ~crc[15];

endmodule

// File: rtl/usb_line_encoder.sv
// Bit timer, bit stuffer, NRZI driver and EOP generator for the full-speed line.
`timescale 1ns/100ps

module usb_line_encoder
(
	input  logic clk,
	input  logic n_rst,
	input  logic pkt_active,
	input  logic tx_bit,
	input  logic crc_bit,
	input  logic crc_phase,
	input  logic create_eop,
	output logic bit_strobe,
	output logic tx_hold,
	output logic eop_done,
	output logic dp,
	output logic dm,
	output logic tx_active
);

	logic [1:0] state;
	logic [usb_tx_pkg::BIT_CNT_W-1:0] bit_timer;
	logic [usb_tx_pkg::RUN_W-1:0] ones_cnt;
	logic [usb_tx_pkg::SE0_W-1:0] se0_cnt;
	logic eop_req;
	logic stuff_slot;
	logic data_bit;

	assign bit_strobe = (state != usb_tx_pkg::ENC_IDLE) && (bit_timer == usb_tx_pkg::BIT_LAST);
	assign stuff_slot = (state == usb_tx_pkg::ENC_DATA) && (ones_cnt == usb_tx_pkg::RUN_LIMIT);
	assign tx_hold = bit_strobe && stuff_slot;
	assign data_bit = crc_phase ? crc_bit : tx_bit;
	assign tx_active = (state != usb_tx_pkg::ENC_IDLE);

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			state <= usb_tx_pkg::ENC_IDLE;
			bit_timer <= '0;
			ones_cnt <= '0;
			se0_cnt <= '0;
			eop_req <= 1'b0;
			eop_done <= 1'b0;
			dp <= 1'b1;                               // idle J.
			dm <= 1'b0;
		end
		else
		begin
			eop_done <= 1'b0;
			if (create_eop)
				eop_req <= 1'b1;

			if (state == usb_tx_pkg::ENC_IDLE || bit_strobe)
				bit_timer <= '0;
			else
				bit_timer <= bit_timer + 1'b1;

			case (state)
				usb_tx_pkg::ENC_IDLE:
				begin
					if (pkt_active)
						state <= usb_tx_pkg::ENC_DATA;
				end
				usb_tx_pkg::ENC_DATA:
				begin
					if (bit_strobe)
					begin
						if (stuff_slot || (!eop_req && !data_bit))
						begin
							dp <= ~dp;                // a zero, sent or stuffed, is a transition.
							dm <= ~dm;
							ones_cnt <= '0;
						end
						else if (eop_req)
						begin
							dp <= 1'b0;
							dm <= 1'b0;
							se0_cnt <= '0;
							eop_req <= 1'b0;
							state <= usb_tx_pkg::ENC_SE0;
						end
						else
							ones_cnt <= ones_cnt + 1'b1;
					end
				end
				usb_tx_pkg::ENC_SE0:
				begin
					if (bit_strobe)
					begin
						if (se0_cnt == usb_tx_pkg::SE0_LAST)
						begin
							dp <= 1'b1;
							dm <= 1'b0;
							state <= usb_tx_pkg::ENC_J;
						end
						else
							se0_cnt <= se0_cnt + 1'b1;
					end
				end
				default:
				begin
					if (bit_strobe)
					begin
						ones_cnt <= '0;
						eop_done <= 1'b1;            // one full bit time of J is out.
						state <= usb_tx_pkg::ENC_IDLE;
					end
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	// line checks
	// ----------------------------------------------------------
	a_no_se1: assert property (@(posedge clk) disable iff (!n_rst) !(dp && dm))
		else $error("dp and dm both high");

	a_eop_in_data: assert property (@(posedge clk) disable iff (!n_rst)
		create_eop |-> (state == usb_tx_pkg::ENC_DATA) && !eop_req)
		else $error("end of packet requested outside a packet or while one is pending");

endmodule

// File: rtl/usb_tx_top.sv
// Full-speed USB transmit path joining the FIFO, serializer, CRC16 generator and line encoder.
`timescale 1ns/100ps

module usb_tx_top
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic       in_valid,
	input  logic [7:0] in_byte,
	input  logic       in_last,
	output logic       credit_return,
	output logic       dp,
	output logic       dm,
	output logic       tx_active
);

	logic [7:0] fifo_byte;
	logic fifo_last;
	logic fifo_empty;
	logic fifo_pop;
	logic bit_strobe;
	logic tx_hold;
	logic eop_done;
	logic tx_bit;
	logic pkt_active;
	logic crc_phase;
	logic crc_clear;
	logic crc_enable;
	logic create_eop;
	logic crc_bit;

	usb_tx_fifo u_fifo (.clk(clk), .n_rst(n_rst), .in_valid(in_valid), .in_byte(in_byte),
		.in_last(in_last), .fifo_pop(fifo_pop), .fifo_byte(fifo_byte), .fifo_last(fifo_last),
		.fifo_empty(fifo_empty), .credit_return(credit_return));

	usb_pkt_serializer u_serializer (.clk(clk), .n_rst(n_rst), .fifo_byte(fifo_byte),
		.fifo_last(fifo_last), .fifo_empty(fifo_empty), .bit_strobe(bit_strobe),
		.tx_hold(tx_hold), .eop_done(eop_done), .fifo_pop(fifo_pop), .tx_bit(tx_bit),
		.pkt_active(pkt_active), .crc_phase(crc_phase), .crc_clear(crc_clear),
		.crc_enable(crc_enable), .create_eop(create_eop));

	// runs beside the serializer on the same strobes.
	usb_crc16 u_crc (.clk(clk), .n_rst(n_rst), .crc_clear(crc_clear), .crc_enable(crc_enable),
		.crc_phase(crc_phase), .tx_bit(tx_bit), .bit_strobe(bit_strobe), .tx_hold(tx_hold),
		.crc_bit(crc_bit));

	usb_line_encoder u_encoder (.clk(clk), .n_rst(n_rst), .pkt_active(pkt_active),
		.tx_bit(tx_bit), .crc_bit(crc_bit), .crc_phase(crc_phase), .create_eop(create_eop),
		.bit_strobe(bit_strobe), .tx_hold(tx_hold), .eop_done(eop_done), .dp(dp), .dm(dm),
		.tx_active(tx_active));

endmodule

// File: verif/usb_tx_tb.sv
// Testbench for the USB transmit path with host credit model, line decoder and packet checker.
`timescale 1ns/100ps

module usb_tx_tb;

	typedef logic [7:0] byte_q_t[$];

	localparam int NUM_PKTS = 24;
	localparam int MAX_PKT_BITS = 140;               // 14 bytes with stuffing and EOP.
	localparam longint WATCHDOG_NS = longint'(NUM_PKTS) * MAX_PKT_BITS
		* usb_tx_pkg::BIT_CLKS * 2 * 8 + 5000;

	logic clk;
	logic n_rst;
	logic in_valid;
	logic [7:0] in_byte;
	logic in_last;
	logic credit_return;
	logic dp;
	logic dm;
	logic tx_active;

	int credits = usb_tx_pkg::FIFO_DEPTH;
	int pushed = 0;
	int returned = 0;
	int sent = 0;
	int checked = 0;
	int errors = 0;
	int stuffs = 0;
	int failed_tests = 0;
	int tests_run = 0;
	logic [7:0] exp_bytes[$];
	int exp_len[$];
	logic [7:0] rx_bytes[$];
	int rx_len[$];

	usb_tx_top dut (.clk(clk), .n_rst(n_rst), .in_valid(in_valid), .in_byte(in_byte),
		.in_last(in_last), .credit_return(credit_return), .dp(dp), .dm(dm),
		.tx_active(tx_active));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------
	function automatic byte_q_t expected_packet(input byte_q_t pkt);
		byte_q_t q;
		usb_tx_pkg::usb_pid_byte_t pid;
		logic [15:0] crc;
		q.push_back(8'h80);                      // SYNC.
		foreach (pkt[i])
			q.push_back(pkt[i]);
		pid.raw = pkt[0];
		if (pid.fields.pid[1:0] == 2'b11)
		begin
			crc = 16'hFFFF;
			for (int i = 1; i < pkt.size(); i++)
				for (int b = 0; b < 8; b++)
					crc = (crc[0] ^ pkt[i][b]) ? ((crc >> 1) ^ 16'hA001) : (crc >> 1);
			crc = ~crc;
			q.push_back(crc[7:0]);                 // low byte leaves first.
			q.push_back(crc[15:8]);
		end
		return q;
	endfunction

	// ----------------------------------------------------------
	// host side
	// ----------------------------------------------------------
	task automatic step();
		@(negedge clk);
		if (credit_return)
		begin
			credits++;
			returned++;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_packet(input byte_q_t pkt);
		byte_q_t exp;
		exp = expected_packet(pkt);
		foreach (exp[i])
			exp_bytes.push_back(exp[i]);
		exp_len.push_back(exp.size());
		sent++;
		for (int i = 0; i < pkt.size(); i++)
		begin
			while (credits == 0)
				step();                           // stall until the FIFO frees a slot.
			in_valid = 1'b1;
			in_byte = pkt[i];
			in_last = (i == pkt.size() - 1);
			credits--;
			pushed++;
			step();
		end
	endtask

	task automatic finish_test(input int num, input string name, input int err_start);
		while (checked < sent)
			step();
		tests_run++;
		if (errors == err_start)
			$display("test %0d %s: ok", num, name);
		else
		begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - err_start);
		end
	endtask

	function automatic byte_q_t random_packet(input logic [7:0] pid, input int len);
		byte_q_t p;
		p.push_back(pid);
		for (int i = 0; i < len; i++)
			p.push_back(8'($urandom));
		return p;
	endfunction

	// ----------------------------------------------------------
	// line monitor
	// ----------------------------------------------------------
	task automatic decode_packet();
		logic prev;
		logic bitv;
		logic [7:0] cur;
		int ones;
		int nbits;
		int count;
		int se0;
		prev = 1'b1;
		cur = '0;
		ones = 0;
		nbits = 0;
		count = 0;
		repeat (usb_tx_pkg::BIT_CLKS / 2) @(negedge clk);   // move to mid bit.
		while (dp || dm)
		begin
			bitv = (dp == prev);
			prev = dp;
			if (ones == usb_tx_pkg::STUFF_RUN && !bitv)
			begin
				stuffs++;
				ones = 0;
			end
			else
			begin
				assert (ones != usb_tx_pkg::STUFF_RUN)
				else
				begin
					$display("Error at %0t ns: seven equal line levels", $time);
					errors++;
				end
				ones = bitv ? ones + 1 : 0;
				cur = {bitv, cur[7:1]};
				nbits++;
				if (nbits % 8 == 0)
				begin
					rx_bytes.push_back(cur);
					count++;
				end
			end
			repeat (usb_tx_pkg::BIT_CLKS) @(negedge clk);
		end
		se0 = 0;
		while (!dp && !dm)
		begin
			se0++;
			repeat (usb_tx_pkg::BIT_CLKS) @(negedge clk);
		end
		assert (se0 == usb_tx_pkg::EOP_SE0_BITS && dp && !dm && nbits % 8 == 0)
		else
		begin
			$display("Error at %0t ns: bad EOP, %0d SE0 bits, %0d payload bits", $time,
				se0, nbits);
			errors++;
		end
		rx_len.push_back(count);
	endtask

	initial
	begin
		forever
		begin
			@(negedge clk);
			if (n_rst && !dp && dm)
				decode_packet();
		end
	end

	// the compare process pairs each decoded packet with the oldest expected one.
	initial
	begin
		int rl;
		int el;
		logic [7:0] rb;
		logic [7:0] eb;
		forever
		begin
			@(negedge clk);
			if (rx_len.size() > 0)
			begin
				rl = rx_len.pop_front();
				el = (exp_len.size() > 0) ? exp_len.pop_front() : 0;
				assert (rl == el)
				else
				begin
					$display("Error at %0t ns: packet %0d has %0d bytes, expected %0d",
						$time, checked, rl, el);
					errors++;
				end
				for (int i = 0; i < rl || i < el; i++)
				begin
					rb = (i < rl) ? rx_bytes.pop_front() : 8'hxx;
					eb = (i < el) ? exp_bytes.pop_front() : 8'hxx;
					assert (rb === eb)
					else
					begin
						$display("Error at %0t ns: packet %0d byte %0d is %h, expected %h",
							$time, checked, i, rb, eb);
						errors++;
					end
				end
				checked++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the DUT stopped sending packets");
		$display("=== FAIL ===");
		$finish;
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial
	begin
		int e0;
		int s0;
		byte_q_t p;
		logic [7:0] pids [3];
		pids = '{8'hD2, 8'hC3, 8'h4B};
		void'($urandom(32'h6667));
		n_rst = 1'b0;
		in_valid = 1'b0;
		in_byte = '0;
		in_last = 1'b0;
		repeat (10) @(negedge clk);
		n_rst = 1'b1;

		e0 = errors;
		repeat (20)
		begin
			step();
			assert (dp && !dm && !tx_active && !credit_return)
			else
			begin
				$display("Error at %0t ns: line not idle after reset", $time);
				errors++;
			end
		end
		finish_test(1, "reset idle", e0);

		e0 = errors;
		p = {8'hD2};
		send_packet(p);
		finish_test(2, "ACK handshake", e0);

		e0 = errors;
		send_packet(random_packet(8'hC3, 6));
		send_packet(random_packet(8'h4B, 5));
		finish_test(3, "DATA0 and DATA1", e0);

		e0 = errors;
		s0 = stuffs;
		p = {8'hC3, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF};
		send_packet(p);
		while (checked < sent)
			step();
		assert (stuffs - s0 >= 10)
		else
		begin
			$display("Error at %0t ns: only %0d stuffed bits seen", $time, stuffs - s0);
			errors++;
		end
		finish_test(4, "bit stuffing", e0);

		e0 = errors;
		for (int n = 0; n < 20; n++)
		begin
			p = random_packet(pids[$urandom % 3], 0);
			if (p[0] != 8'hD2)
				p = random_packet(p[0], $urandom % 11);
			send_packet(p);
			repeat ($urandom % 4) step();
		end
		while (checked < sent)
			step();                               // every byte has been popped by now.
		assert (returned == pushed && credits == usb_tx_pkg::FIFO_DEPTH)
		else
		begin
			$display("Error at %0t ns: %0d credits back for %0d pushes, %0d held", $time,
				returned, pushed, credits);
			errors++;
		end
		finish_test(5, "random back to back", e0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: compile.f
rtl/usb_tx_pkg.sv
rtl/usb_tx_fifo.sv
rtl/usb_pkt_serializer.sv
rtl/usb_crc16.sv
rtl/usb_line_encoder.sv
rtl/usb_tx_top.sv
verif/usb_tx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the USB transmit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f compile.f \
	--top-module usb_tx_tb \
	--Mdir "$BUILD_DIR" \
	-o usb_tx_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/usb_tx_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
